/* dv/apb_subsys_tb.sv */
/* Testbench for the APB subsystem. One request is outstanding at a time, and each
   response is checked against a mirror of both memories and of the window bounds */
`timescale 1ns/1ps

module apb_subsys_tb import apb_bus_pkg::*; ();

    localparam int DEPTH0     = 256;
    localparam int WAIT0      = 0;
    localparam int DEPTH1     = 64;
    localparam int WAIT1      = 2;
    localparam int MAX_DEPTH  = 256;
    localparam int SEED       = 40;
    localparam int NUM_RAND   = 300;
    // Roughly 430 requests of at most 12 cycles each plus config traffic
    localparam int MAX_CYCLES = 20000;

    logic        i_clk;
    logic        i_nrst;
    logic        i_req_valid;
    sys_req_t    i_req;
    logic        i_cfg_wr;
    logic [2:0]  i_cfg_idx;
    logic [31:0] i_cfg_wdata;
    logic        o_req_ready;
    logic        o_resp_valid;
    sys_resp_t   o_resp;
    logic [31:0] o_cfg_rdata;

    // Reference model state
    logic [31:0] mirror [NUM_APB_SLV][MAX_DEPTH];
    logic [31:0] win_start [NUM_APB_SLV];
    logic [31:0] win_end [NUM_APB_SLV];
    sys_resp_t   exp_q [$];
    int          resp_cnt = 0;
    int          cycle_cnt = 0;

    apb_subsys_top #(
        .DEPTH0 (DEPTH0),
        .WAIT0  (WAIT0),
        .DEPTH1 (DEPTH1),
        .WAIT1  (WAIT1)
    ) dut0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_idx    (i_cfg_idx),
        .i_cfg_wdata  (i_cfg_wdata),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp),
        .o_cfg_rdata  (o_cfg_rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic check_equal(input logic [64:0] got, input logic [64:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic int depth_of(int slv);
        return (slv == 0) ? DEPTH0 : DEPTH1;
    endfunction

    // Lowest window that holds the address or -1
    function automatic int find_window(logic [31:0] addr);
        int hit;
        hit = -1;
        for (int i = NUM_APB_SLV - 1; i >= 0; i--) begin
            if ((addr >= win_start[i]) && (addr < win_end[i])) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    function automatic logic refused(sys_req_t r);
        return (find_window(r.addr) < 0) || (r.size == 4'd0) || (r.size > 4'd8);
    endfunction

    // Expected response from the mirror as it was before this request
    function automatic sys_resp_t exp_resp(sys_req_t r);
        sys_resp_t   res;
        int          slv;
        int          lane;
        int          beats;
        logic [31:0] off;
        res.rdata = '1;     // Default slave answer
        res.err   = 1'b1;
        if (refused(r)) begin
            return res;
        end
        res.rdata = '0;
        res.err   = 1'b0;
        slv   = find_window(r.addr);
        off   = {r.addr[31:2], 2'b00} - win_start[slv];
        lane  = r.addr[2];
        beats = (r.size > 4'd4) ? 2 : 1;
        for (int b = 0; b < beats; b++) begin
            if (off[31:2] >= depth_of(slv)) begin
                res.err = 1'b1;         // Lane stays zero
            end else if (!r.write) begin
                res.rdata[32*lane +: 32] = mirror[slv][off[31:2]];
            end
            off  = off + 32'd4;
            lane = 1 - lane;
        end
        return res;
    endfunction

    task automatic update_mirror(input sys_req_t r);
        int          slv;
        int          beats;
        logic        upper;
        logic [31:0] off;
        logic [31:0] data;
        logic [3:0]  strb;
        if (refused(r) || !r.write) begin
            return;
        end
        slv   = find_window(r.addr);
        off   = {r.addr[31:2], 2'b00} - win_start[slv];
        beats = (r.size > 4'd4) ? 2 : 1;
        for (int b = 0; b < beats; b++) begin
            upper = (b == 1) || r.addr[2];     // Second beat uses the upper lane
            data  = upper ? r.wdata[63:32] : r.wdata[31:0];
            strb  = upper ? r.wstrb[7:4] : r.wstrb[3:0];
            if (off[31:2] < depth_of(slv)) begin
                for (int k = 0; k < 4; k++) begin
                    if (strb[k]) begin
                        mirror[slv][off[31:2]][8*k +: 8] = data[8*k +: 8];
                    end
                end
            end
            off = off + 32'd4;
        end
    endtask

    function automatic sys_req_t make_req(logic [31:0] addr, logic [3:0] size, logic write,
                                          logic [63:0] wdata, logic [7:0] wstrb);
        sys_req_t r;
        r.addr  = addr;
        r.size  = size;
        r.write = write;
        r.wdata = wdata;
        r.wstrb = wstrb;
        return r;
    endfunction

    // Random address inside a window and within the slave depth
    function automatic logic [31:0] pick_addr(int slv, int align);
        logic [31:0] span;
        span = win_end[slv] - win_start[slv];
        if (span > 4 * depth_of(slv)) begin
            span = 4 * depth_of(slv);
        end
        return win_start[slv] + (($urandom % span) / align) * align;
    endfunction

    task automatic send_req(input sys_req_t r);
        int target;
        target = resp_cnt + 1;
        @(negedge i_clk);
        i_req       = r;
        i_req_valid = 1'b1;
        while (!o_req_ready) begin
            @(negedge i_clk);
        end
        exp_q.push_back(exp_resp(r));   // Taken on the coming edge
        update_mirror(r);
        @(negedge i_clk);
        i_req_valid = 1'b0;
        while (resp_cnt < target) begin
            check_equal(65'(o_req_ready), 65'(0), "ready while a request is open");
            @(negedge i_clk);
        end
        check_equal(65'(o_req_ready), 65'(1), "ready after the response");
    endtask

    task automatic cfg_write(input logic [2:0] idx, input logic [31:0] val);
        @(negedge i_clk);
        i_cfg_wr    = 1'b1;
        i_cfg_idx   = idx;
        i_cfg_wdata = val;
        @(negedge i_clk);
        i_cfg_wr = 1'b0;
        if (idx < 3'd4) begin
            if (idx[0]) begin
                win_end[idx[2:1]] = val;
            end else begin
                win_start[idx[2:1]] = val;
            end
        end
    endtask

    task automatic cfg_readback(input logic [2:0] idx);
        logic [31:0] exp;
        exp = '0;
        if (idx < 3'd4) begin
            exp = idx[0] ? win_end[idx[2:1]] : win_start[idx[2:1]];
        end
        @(negedge i_clk);
        i_cfg_idx = idx;
        @(posedge i_clk);
        check_equal(65'(o_cfg_rdata), 65'(exp), $sformatf("cfg read-back idx %0d", idx));
    endtask

    always @(posedge i_clk) begin : compare
        sys_resp_t e;
        if (i_nrst && o_resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Response pulse seen with no request outstanding");
                $display("CHECKS FAILED");
                $fatal(1, "unexpected response");
            end else begin
                e = exp_q.pop_front();
                check_equal(o_resp, e, $sformatf("response %0d", resp_cnt));
                resp_cnt++;
            end
        end
    end

    always @(posedge i_clk) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        logic [31:0] a;
        int          slv;
        logic [3:0]  sz;
        void'($urandom(SEED));
        i_nrst      = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_cfg_wr    = 1'b0;
        i_cfg_idx   = '0;
        i_cfg_wdata = '0;
        for (int i = 0; i < NUM_APB_SLV; i++) begin
            win_start[i] = DEF_WIN_START[i];
            win_end[i]   = DEF_WIN_END[i];
            for (int j = 0; j < MAX_DEPTH; j++) begin
                mirror[i][j] = '0;
            end
        end
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;

        // Single words in both lanes of both windows
        for (int w = 0; w < NUM_APB_SLV; w++) begin
            for (int ln = 0; ln < 2; ln++) begin
                a = DEF_WIN_START[w] + 32'h40 + 4 * ln;
                send_req(make_req(a, 4'd4, 1'b1, {$urandom, $urandom}, 8'hFF));
                send_req(make_req(a, 4'd4, 1'b0, '0, '0));
            end
        end

        repeat (20) begin  // Two-beat accesses
            a = pick_addr($urandom % 2, 8);
            send_req(make_req(a, 4'd8, 1'b1, {$urandom, $urandom}, 8'hFF));
            send_req(make_req(a, 4'd8, 1'b0, '0, '0));
        end

        // Fill a word pair and then overwrite random bytes only
        repeat (20) begin
            a = pick_addr($urandom % 2, 8);
            send_req(make_req(a, 4'd8, 1'b1, {$urandom, $urandom}, 8'hFF));
            send_req(make_req(a, 4'd8, 1'b1, {$urandom, $urandom}, 8'($urandom)));
            send_req(make_req(a, 4'd8, 1'b0, '0, '0));
        end

        send_req(make_req(32'h0000_0000, 4'd4, 1'b0, '0, '0));
        send_req(make_req(32'h0000_0FFC, 4'd4, 1'b1, '1, 8'hFF));
        send_req(make_req(32'h0000_2400, 4'd8, 1'b0, '0, '0));
        send_req(make_req(32'hFFFF_FFF8, 4'd8, 1'b1, '1, 8'hFF));
        send_req(make_req(32'h0000_1000, 4'd0, 1'b0, '0, '0));     // Bad sizes
        send_req(make_req(32'h0000_1000, 4'd9, 1'b1, '1, 8'hFF));
        send_req(make_req(32'h0000_1040, 4'd8, 1'b0, '0, '0));

        for (int i = 0; i < 8; i++) begin
            cfg_readback(3'(i));
        end
        cfg_write(3'd0, 32'h0000_4000);
        cfg_write(3'd1, 32'h0000_4800);     // Wider than the 256 words behind it
        cfg_write(3'd2, 32'h0000_8000);
        cfg_write(3'd3, 32'h0000_8200);
        cfg_write(3'd5, 32'h0000_DEAD);     // No such window
        for (int i = 0; i < 8; i++) begin
            cfg_readback(3'(i));
        end
        send_req(make_req(32'h0000_4010, 4'd8, 1'b1, {$urandom, $urandom}, 8'hFF));
        send_req(make_req(32'h0000_4010, 4'd8, 1'b0, '0, '0));
        send_req(make_req(32'h0000_8020, 4'd4, 1'b1, {$urandom, $urandom}, 8'h0F));
        send_req(make_req(32'h0000_8020, 4'd4, 1'b0, '0, '0));
        send_req(make_req(32'h0000_4404, 4'd4, 1'b0, '0, '0));
        send_req(make_req(32'h0000_43FC, 4'd8, 1'b0, '0, '0));     // Second beat past DEPTH
        send_req(make_req(32'h0000_8100, 4'd4, 1'b1, '1, 8'hFF));
        send_req(make_req(32'h0000_1000, 4'd4, 1'b0, '0, '0));     // Old window now unmapped

        repeat (NUM_RAND) begin
            slv = $urandom % 8;
            a   = (slv == 0) ? $urandom : pick_addr(slv % 2, 1);
            sz  = ($urandom % 16 == 0) ? 4'd9 : 4'(1 + $urandom % 8);
            send_req(make_req(a, sz, 1'($urandom), {$urandom, $urandom}, 8'($urandom)));
        end

        repeat (4) @(negedge i_clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* logic/apb_bridge.sv */
/* Single-request bridge from a 64-bit port to 32-bit APB. 8-byte accesses run as two
   beats and the response has no back-pressure, so the requester must take the pulse */
`timescale 1ns/1ps

module apb_bridge import apb_bus_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_req_valid,
    input  sys_req_t                   i_req,
    input  map_vec_t                   i_map,
    input  apb_rsp_t [NUM_APB_SLV-1:0] i_apb_rsp,
    output logic                       o_req_ready,
    output logic                       o_resp_valid,
    output sys_resp_t                  o_resp,
    output apb_req_t [NUM_APB_SLV-1:0] o_apb_req
);

    bridge_state_e state_q;
    logic [SEL_W-1:0] sel_q;        // Latched slave or NUM_APB_SLV for the default slave
    logic             beat_q;       // Set during the second beat
    logic             two_beat_q;

    // Payload of the running transfer
    logic [31:0] paddr_q;
    logic        write_q;
    logic [63:0] wdata_q;
    logic [7:0]  wstrb_q;
    logic        lane_q;            // Lane of the current beat from address bit 2
    logic [63:0] rdata_q;
    logic        err_q;

    logic [SEL_W-1:0] hit_idx;
    logic [31:0]      hit_start;
    logic             size_bad;
    logic             go_apb;
    logic             accept;
    apb_rsp_t         cur_rsp;
    logic             beat_done;
    logic             more_beat;
    logic             use_upper;
    apb_req_t         beat_req;
    logic [NUM_APB_SLV-1:0] psel_vec;
    logic [NUM_APB_SLV-1:0] pen_vec;

    // Address decode where the lowest window wins
    always_comb begin
        hit_idx   = SEL_W'(NUM_APB_SLV);
        hit_start = '0;
        for (int i = NUM_APB_SLV - 1; i >= 0; i--) begin
            if ((i_req.addr >= i_map[i].start_addr) && (i_req.addr < i_map[i].end_addr)) begin
                hit_idx   = SEL_W'(i);
                hit_start = i_map[i].start_addr;
            end
        end
    end

    assign size_bad = (i_req.size == 4'd0) || (i_req.size > 4'd8);
    assign go_apb   = !size_bad && (hit_idx != SEL_W'(NUM_APB_SLV));
    assign accept   = i_req_valid && (state_q == ST_IDLE);

    // Response of the selected slave
    always_comb begin
        cur_rsp = '0;
        for (int i = 0; i < NUM_APB_SLV; i++) begin
            if (sel_q == i) begin
                cur_rsp = i_apb_rsp[i];
            end
        end
    end

    assign beat_done = (state_q == ST_ACCESS) && cur_rsp.pready;
    assign more_beat = two_beat_q && !beat_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q    <= ST_IDLE;
            sel_q      <= SEL_W'(NUM_APB_SLV);
            beat_q     <= 1'b0;
            two_beat_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_req_valid) begin
                        sel_q      <= go_apb ? hit_idx : SEL_W'(NUM_APB_SLV);
                        beat_q     <= 1'b0;
                        two_beat_q <= (i_req.size > 4'd4);
                        state_q    <= go_apb ? ST_SETUP : ST_RESP;   // Default slave answers at once
                    end
                end
                ST_SETUP: state_q <= ST_ACCESS;
                ST_ACCESS: begin
                    if (cur_rsp.pready) begin
                        if (more_beat) begin
                            beat_q  <= 1'b1;
                            state_q <= ST_SETUP;
                        end else begin
                            state_q <= ST_RESP;
                        end
                    end
                end
                default: state_q <= ST_IDLE;    // ST_RESP lasts one cycle
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            write_q <= i_req.write;
            wdata_q <= i_req.wdata;     // Second beat must not see the live input
            wstrb_q <= i_req.wstrb;
            paddr_q <= {i_req.addr[31:2], 2'b00} - hit_start;
            lane_q  <= i_req.addr[2];
            rdata_q <= go_apb ? '0 : '1;
            err_q   <= !go_apb;
        end else if (beat_done) begin
            if (lane_q) begin
                rdata_q[63:32] <= cur_rsp.prdata;
            end else begin
                rdata_q[31:0] <= cur_rsp.prdata;
            end
            err_q <= err_q | cur_rsp.pslverr;
            if (more_beat) begin
                paddr_q <= paddr_q + 32'd4;
                lane_q  <= ~lane_q;     // Next word flips address bit 2
            end
        end
    end

    // Second beat always carries the upper lane
    assign use_upper = beat_q | lane_q;

    always_comb begin
        beat_req         = '0;
        beat_req.paddr   = paddr_q;
        beat_req.pwrite  = write_q;
        beat_req.pwdata  = use_upper ? wdata_q[63:32] : wdata_q[31:0];
        beat_req.pstrb   = use_upper ? wstrb_q[7:4] : wstrb_q[3:0];
        beat_req.psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
        beat_req.penable = (state_q == ST_ACCESS);
        for (int i = 0; i < NUM_APB_SLV; i++) begin
            o_apb_req[i] = (beat_req.psel && (sel_q == i)) ? beat_req : '0;
            psel_vec[i]  = o_apb_req[i].psel;
            pen_vec[i]   = o_apb_req[i].penable;
        end
    end

    assign o_req_ready  = (state_q == ST_IDLE);
    assign o_resp_valid = (state_q == ST_RESP);
    assign o_resp       = '{rdata: rdata_q, err: err_q};

    a_psel_mapped: assert property (@(posedge i_clk) disable iff (!i_nrst)
        beat_req.psel |-> (sel_q < SEL_W'(NUM_APB_SLV)))
        else $error("psel without a mapped slave");

    // Setup and access of one beat stay on the same slave
    a_penable_psel: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (|pen_vec) |-> ((pen_vec == psel_vec) && ($past(psel_vec) == psel_vec)))
        else $error("penable without psel held since the setup phase");

    a_resp_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid |=> !o_resp_valid)
        else $error("response valid held longer than one cycle");

endmodule

/* logic/apb_bus_pkg.sv */
/* Types shared by the request to APB bridge, its map registers and the memory slaves.
   Window end bounds are exclusive; a size outside 1..8 bytes is treated as unmapped */
package apb_bus_pkg;

    localparam int NUM_APB_SLV = 2;                       // Mapped APB slaves
    localparam int SEL_W = $clog2(NUM_APB_SLV + 1);       // One extra code marks the default slave

    // Reset bounds of each window
    localparam logic [31:0] DEF_WIN_START [NUM_APB_SLV] = '{32'h0000_1000, 32'h0000_2000};
    localparam logic [31:0] DEF_WIN_END   [NUM_APB_SLV] = '{32'h0000_2000, 32'h0000_2400};

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  size;      // Bytes, 1 to 8
        logic        write;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
    } sys_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        err;
    } sys_resp_t;

    // Bridge to slave, paddr is the offset inside the window
    typedef struct packed {
        logic [31:0] paddr;
        logic        pwrite;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
        logic        psel;
        logic        penable;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [31:0] start_addr;
        logic [31:0] end_addr;
    } win_t;

    typedef win_t [NUM_APB_SLV-1:0] map_vec_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_RESP
    } bridge_state_e;

endpackage

/* logic/apb_map_regs.sv */
/* Window bound registers; even idx is a start, odd idx an end. Indices past the last
   slave ignore writes and read back zero */
`timescale 1ns/1ps

module apb_map_regs import apb_bus_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_cfg_wr,
    input  logic [2:0]  i_cfg_idx,
    input  logic [31:0] i_cfg_wdata,
    output logic [31:0] o_cfg_rdata,
    output map_vec_t    o_map
);

    map_vec_t   map_q;
    logic [1:0] slv;        // Window number
    logic       is_end;     // Odd index selects the end bound

    assign slv    = i_cfg_idx[2:1];
    assign is_end = i_cfg_idx[0];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < NUM_APB_SLV; i++) begin
                map_q[i].start_addr <= DEF_WIN_START[i];
                map_q[i].end_addr   <= DEF_WIN_END[i];
            end
        end else if (i_cfg_wr) begin
            for (int i = 0; i < NUM_APB_SLV; i++) begin
                if (slv == i) begin
                    if (is_end) begin
                        map_q[i].end_addr <= i_cfg_wdata;
                    end else begin
                        map_q[i].start_addr <= i_cfg_wdata;
                    end
                end
            end
        end
    end

    // Read-back mux, unused indices stay zero
    always_comb begin
        o_cfg_rdata = '0;
        for (int i = 0; i < NUM_APB_SLV; i++) begin
            if (slv == i) begin
                o_cfg_rdata = is_end ? map_q[i].end_addr : map_q[i].start_addr;
            end
        end
    end

    assign o_map = map_q;

    // An X strobe would corrupt the map silently
    a_cfg_wr_known: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !$isunknown(i_cfg_wr))
        else $error("cfg write strobe is unknown");

endmodule

/* logic/apb_mem_slave.sv */
/* APB word memory with byte strobes and WAIT_STATES extra access cycles.
   Offsets at or past DEPTH words answer pslverr with zero data and write nothing */
`timescale 1ns/1ps

module apb_mem_slave import apb_bus_pkg::*; #(
    parameter int DEPTH       = 256,
    parameter int WAIT_STATES = 0
) (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb
);

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]   mem [DEPTH];
    logic [CW-1:0] wait_cnt;
    logic          access;
    logic          in_range;
    logic          ready;
    logic [IW-1:0] widx;

    assign access   = i_apb.psel && i_apb.penable;
    assign in_range = (i_apb.paddr[31:2] < DEPTH);
    assign widx     = i_apb.paddr[IW+1:2];
    assign ready    = access && (wait_cnt == CW'(WAIT_STATES));

    // Counts access cycles until pready
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wait_cnt <= '0;
        end else if (access && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ready && i_apb.pwrite && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (i_apb.pstrb[b]) begin
                    mem[widx][8*b +: 8] <= i_apb.pwdata[8*b +: 8];
                end
            end
        end
    end

    assign o_apb.pready  = ready;
    assign o_apb.pslverr = ready && !in_range;
    assign o_apb.prdata  = (ready && in_range && !i_apb.pwrite) ? mem[widx] : '0;

    // Access phase must follow a setup cycle of the same transfer
    a_setup_first: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_apb.penable) |-> $past(i_apb.psel && !i_apb.penable))
        else $error("penable rose without a setup phase");

endmodule

/* logic/apb_subsys_top.sv */
/* Bridge, window registers and two APB memories. Slave depth and wait states are
   set per slave by the parameters below */
`timescale 1ns/1ps

module apb_subsys_top import apb_bus_pkg::*; #(
    parameter int DEPTH0 = 256,
    parameter int WAIT0  = 0,
    parameter int DEPTH1 = 64,
    parameter int WAIT1  = 2
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  sys_req_t    i_req,
    input  logic        i_cfg_wr,
    input  logic [2:0]  i_cfg_idx,
    input  logic [31:0] i_cfg_wdata,
    output logic        o_req_ready,
    output logic        o_resp_valid,
    output sys_resp_t   o_resp,
    output logic [31:0] o_cfg_rdata
);

    map_vec_t                   map;
    apb_req_t [NUM_APB_SLV-1:0] apb_req;
    apb_rsp_t [NUM_APB_SLV-1:0] apb_rsp;

    apb_map_regs map0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_idx   (i_cfg_idx),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .o_map       (map)
    );

    apb_bridge bridge0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_map        (map),
        .i_apb_rsp    (apb_rsp),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp),
        .o_apb_req    (apb_req)
    );

    // Window 0 memory
    apb_mem_slave #(.DEPTH(DEPTH0), .WAIT_STATES(WAIT0)) mem0 (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_apb  (apb_req[0]),
        .o_apb  (apb_rsp[0])
    );

    apb_mem_slave #(.DEPTH(DEPTH1), .WAIT_STATES(WAIT1)) mem1 (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_apb  (apb_req[1]),
        .o_apb  (apb_rsp[1])      // Window 1 memory
    );

endmodule

/* sources.f */
logic/apb_bus_pkg.sv
logic/apb_map_regs.sv
logic/apb_bridge.sv
logic/apb_mem_slave.sv
logic/apb_subsys_top.sv
dv/apb_subsys_tb.sv
